// ==== sim/fetch_stimulus.txt ====
// word 0: number of retires expected, the last one must be the ebreak
// words 1 on: program, one hex word per line, the first at PC_START 80000000
0000000f  // retire count

// straight line start
00100093  // 80000000 addi x1, x0, 1
00200113  // 80000004 addi x2, x0, 2
002081b3  // 80000008 add  x3, x1, x2
0100006f  // 8000000c jal  x0, +16 -> 8000001c

// skipped by the forward jump
00000013  // 80000010 nop, fetched and dropped
00000013  // 80000014 nop
00000013  // 80000018 nop

00118213  // 8000001c addi x4, x3, 1
0040006f  // 80000020 jal  x0, +4, falls through
00420293  // 80000024 addi x5, x4, 4
0180006f  // 80000028 jal  x0, +24 -> 80000040
00000013  // 8000002c nop, fetched and dropped

// reached by the backward jump
40208333  // 80000030 sub  x6, x1, x2
018000ef  // 80000034 jal  x1, +24 -> 8000004c
00000013  // 80000038 nop, fetched and dropped
00000013  // 8000003c nop

00530313  // 80000040 addi x6, x6, 5
fedff06f  // 80000044 jal  x0, -20 -> 80000030
00000013  // 80000048 nop, fetched and dropped

// tail
00108093  // 8000004c addi x1, x1, 1
00310393  // 80000050 addi x7, x2, 3
00100073  // 80000054 ebreak
00000013  // 80000058 nop, never fetched

// ==== list.f ====
hw/fetch_pkg.sv
hw/fetch_unit.sv
hw/jump_unit.sv
hw/pipe_ctrl.sv
hw/fetch_top.sv
sim/tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# compile the fetch subsystem with verilator and run its testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_fetch -f list.f -Mdir obj_dir

status=0
output=$(./obj_dir/Vtb_fetch 2>&1) || status=$?
printf '%s\n' "$output"

# the run passes only if the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx 'NO ERRORS'; then
  echo "simulation passed"
else
  echo "simulation failed, exit status $status"
  exit 1
fi

// ==== sim/tb_fetch.sv ====
// fetch subsystem testbench
// bus memory model with wait states and a reference trace from the stimulus file
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

  localparam int AW = fetch_pkg::ADDR_W;
  localparam int IW = fetch_pkg::INST_W;
  localparam logic [AW-1:0] PC_START = fetch_pkg::PC_START_DEF;

  localparam int RST_CYCLES        = 10;
  localparam int HALT_CYCLES       = 50;
  localparam int CYCLES_PER_RETIRE = 20;  // covers refetch plus worst wait states

  logic          clk = 1'b0;
  logic          rst = 1'b1;
  logic          i_bus_ack;
  logic [IW-1:0] i_bus_rdata;
  logic          o_bus_req;
  logic [AW-1:0] o_bus_addr;
  logic          o_retire_valid;
  logic [AW-1:0] o_retire_pc;
  logic [IW-1:0] o_retire_inst;
  logic          o_halted;

  logic [IW-1:0] stim [0:255];  // word 0 is the retire count
  logic [AW-1:0] exp_pc [$];
  logic [IW-1:0] exp_inst [$];
  int            n_retire;
  int            prog_len;       // program words in the file
  int            discards;       // wasted fetches after taken jumps
  int            handshakes = 0;
  bit            loaded = 1'b0;
  integer        seed = 32'h77a47198;

  fetch_top #(
    .PC_START (PC_START)
  ) UUT (
    .clk            (clk),
    .rst            (rst),
    .i_bus_ack      (i_bus_ack),
    .i_bus_rdata    (i_bus_rdata),
    .o_bus_req      (o_bus_req),
    .o_bus_addr     (o_bus_addr),
    .o_retire_valid (o_retire_valid),
    .o_retire_pc    (o_retire_pc),
    .o_retire_inst  (o_retire_inst),
    .o_halted       (o_halted)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // failure reporting and compare
  ////////////////////////////////////////

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      stop_on_failure($sformatf("ERROR at %0d ns: %s expected %h, actual %h",
                                $time, name, expected, actual));
    end
  endtask

  ////////////////////////////////////////
  // program memory helpers
  ////////////////////////////////////////

  // marks words the file did not write
  function automatic logic [IW-1:0] fill_word(input int k);
    return 32'hbad0_0000 ^ 32'(k);
  endfunction

  function automatic logic [IW-1:0] stim_at(input int k);
    return stim[8'(k)];
  endfunction

  function automatic bit in_program(input logic [AW-1:0] addr);
    return (addr[1:0] == 2'b00) && (addr >= PC_START) &&
           (addr < PC_START + 64'(prog_len) * 64'd4);
  endfunction

  function automatic logic [IW-1:0] word_at(input logic [AW-1:0] addr);
    logic [AW-1:0] word_idx;
    word_idx = ((addr - PC_START) >> 2) + 64'd1;  // skip the count word
    return stim_at(int'(word_idx));
  endfunction

  // j-type offset where imm[20] weighs -2^20
  function automatic logic [AW-1:0] jal_offset(input logic [IW-1:0] inst);
    logic [AW-1:0] off;
    off = 64'(inst[30:21]) << 1;
    off = off | (64'(inst[20]) << 11);
    off = off | (64'(inst[19:12]) << 12);
    if (inst[31]) begin
      off = off - 64'h10_0000;
    end
    return off;
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  task automatic build_expected();
    logic [AW-1:0] pc;
    logic [IW-1:0] inst;
    pc       = PC_START;
    discards = 0;
    for (int i = 0; i < n_retire; i++) begin
      if (!in_program(pc)) begin
        stop_on_failure($sformatf("reference walk left the program at %h", pc));
      end
      inst = word_at(pc);
      exp_pc.push_back(pc);
      exp_inst.push_back(inst);
      if (inst[6:0] == fetch_pkg::OPC_JAL) begin
        if (jal_offset(inst) != 64'd4) begin
          discards++;  // sequential word fetched and dropped
        end
        pc = pc + jal_offset(inst);
      end else begin
        pc = pc + 64'd4;
      end
    end
    if (exp_inst[n_retire-1] != fetch_pkg::INST_EBREAK) begin
      stop_on_failure("the last expected retire in the stimulus file is not an ebreak");
    end
  endtask

  ////////////////////////////////////////
  // bus memory model
  ////////////////////////////////////////

  initial begin : bus_model
    logic [1:0]    delay;
    logic [31:0]   r;
    logic [AW-1:0] addr;
    i_bus_ack   = 1'b0;
    i_bus_rdata = '0;
    wait (!rst);
    forever begin
      @(negedge clk);
      i_bus_ack = 1'b0;
      if (o_bus_req) begin
        addr = o_bus_addr;
        if (!in_program(addr)) begin
          stop_on_failure($sformatf("bus request to %h, outside the program", addr));
        end
        r     = $random(seed);
        delay = r[1:0];  // 0 to 3 wait states
        repeat (delay) begin
          @(negedge clk);
          check_value("o_bus_req", 64'd1, 64'(o_bus_req));
          check_value("o_bus_addr", addr, o_bus_addr);  // held while waiting
        end
        i_bus_rdata = word_at(addr);
        i_bus_ack   = 1'b1;
        handshakes++;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = n_retire * CYCLES_PER_RETIRE + RST_CYCLES + HALT_CYCLES;
    repeat (limit) @(posedge clk);
    stop_on_failure($sformatf("timeout, the run did not finish within %0d cycles", limit));
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : main
    int idx;
    for (int k = 0; k < 256; k++) begin
      stim[8'(k)] = fill_word(k);
    end
    $readmemh("sim/fetch_stimulus.txt", stim);
    n_retire = int'(stim[0]);
    prog_len = 0;
    while (prog_len < 255 && stim_at(prog_len + 1) !== fill_word(prog_len + 1)) begin
      prog_len++;
    end
    if (n_retire < 1 || prog_len < 1) begin
      stop_on_failure("the stimulus file holds no program");
    end
    build_expected();
    loaded = 1'b1;

    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;

    // trace order and values whatever the wait states
    idx = 0;
    while (idx < n_retire) begin
      @(negedge clk);
      if (o_retire_valid) begin
        check_value("o_retire_pc", exp_pc[idx], o_retire_pc);
        check_value("o_retire_inst", 64'(exp_inst[idx]), 64'(o_retire_inst));
        check_value("o_halted", 64'(idx == n_retire - 1), 64'(o_halted));
        idx++;
      end
    end

    // after ebreak nothing moves
    repeat (HALT_CYCLES) begin
      @(negedge clk);
      check_value("o_halted", 64'd1, 64'(o_halted));
      check_value("o_bus_req", 64'd0, 64'(o_bus_req));
      check_value("o_retire_valid", 64'd0, 64'(o_retire_valid));
    end

    // one dropped fetch per taken jump and none for offset 4
    check_value("bus handshakes", 64'(n_retire + discards), 64'(handshakes));

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/fetch_top.sv ====
// fetch subsystem top
// fetch unit, jump decode and pipeline control wired together
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter logic [fetch_pkg::ADDR_W-1:0] PC_START = fetch_pkg::PC_START_DEF
) (
  input  wire                          clk,
  input  wire                          rst,

  // instruction bus
  input  wire                          i_bus_ack,
  input  wire  [fetch_pkg::INST_W-1:0] i_bus_rdata,
  output logic                         o_bus_req,
  output logic [fetch_pkg::ADDR_W-1:0] o_bus_addr,

  // retire trace
  output logic                         o_retire_valid,
  output logic [fetch_pkg::ADDR_W-1:0] o_retire_pc,
  output logic [fetch_pkg::INST_W-1:0] o_retire_inst,
  output logic                         o_halted
);

  // fetch to decode
  logic                         fetched;
  logic [fetch_pkg::ADDR_W-1:0] fetch_pc;
  logic [fetch_pkg::INST_W-1:0] fetch_inst;

  // decode to control and back to fetch
  logic                         dec_valid;
  logic [fetch_pkg::ADDR_W-1:0] dec_pc;
  logic [fetch_pkg::INST_W-1:0] dec_inst;
  logic                         jmp;
  logic [fetch_pkg::ADDR_W-1:0] jmp_addr;
  logic                         next_req;

  fetch_unit #(
    .PC_START (PC_START)
  ) u_fetch (
    .clk               (clk),
    .rst               (rst),
    .i_bus_ack         (i_bus_ack),
    .i_bus_rdata       (i_bus_rdata),
    .o_bus_req         (o_bus_req),
    .o_bus_addr        (o_bus_addr),
    .i_writebacked_req (next_req),
    .i_pc_jmp          (jmp),
    .i_pc_jmpaddr      (jmp_addr),
    .o_pc              (fetch_pc),
    .o_inst            (fetch_inst),
    .o_fetched         (fetched)
  );

  jump_unit u_jump (
    .clk         (clk),
    .rst         (rst),
    .i_fetched   (fetched),
    .i_pc        (fetch_pc),
    .i_inst      (fetch_inst),
    .o_dec_valid (dec_valid),
    .o_pc        (dec_pc),
    .o_inst      (dec_inst),
    .o_jmp       (jmp),
    .o_jmp_addr  (jmp_addr)
  );

  pipe_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .i_dec_valid    (dec_valid),
    .i_pc           (dec_pc),
    .i_inst         (dec_inst),
    .o_next_req     (next_req),
    .o_retire_valid (o_retire_valid),
    .o_retire_pc    (o_retire_pc),
    .o_retire_inst  (o_retire_inst),
    .o_halted       (o_halted)
  );

endmodule

`default_nettype wire

// ==== hw/pipe_ctrl.sv ====
// pipeline control
// retires decoded words, requests the next fetch and stops on ebreak
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
  input  wire                          clk,
  input  wire                          rst,

  input  wire                          i_dec_valid,
  input  wire  [fetch_pkg::ADDR_W-1:0] i_pc,
  input  wire  [fetch_pkg::INST_W-1:0] i_inst,

  output logic                         o_next_req,      // to fetch unit
  output logic                         o_retire_valid,
  output logic [fetch_pkg::ADDR_W-1:0] o_retire_pc,
  output logic [fetch_pkg::INST_W-1:0] o_retire_inst,
  output logic                         o_halted
);

  typedef enum logic {
    ST_RUN  = 1'b0,
    ST_HALT = 1'b1
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   is_ebreak;
  logic   retire_now;

  assign is_ebreak  = (i_inst == fetch_pkg::INST_EBREAK);
  assign retire_now = i_dec_valid & (state == ST_RUN);

  ////////////////////////////////////////
  // state
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ST_RUN: begin
        if (retire_now && is_ebreak) begin
          state_nxt = ST_HALT;
        end
      end
      ST_HALT: state_nxt = ST_HALT;  // left only by reset
      default: state_nxt = ST_RUN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_RUN;
    end else begin
      state <= state_nxt;
    end
  end

  assign o_halted = (state == ST_HALT);

  ////////////////////////////////////////
  // retire and next request
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      o_retire_valid <= 1'b0;
      o_next_req     <= 1'b0;
    end else begin
      o_retire_valid <= retire_now;
      o_next_req     <= retire_now & ~is_ebreak;  // nothing after ebreak
    end
  end

  // retire trace payload
  always_ff @(posedge clk) begin
    if (retire_now) begin
      o_retire_pc   <= i_pc;
      o_retire_inst <= i_inst;
    end
  end

endmodule

`default_nettype wire

// ==== hw/jump_unit.sv ====
// jump unit
// one decode stage, flags jal and computes its target from the j-immediate
`timescale 1ns/1ps
`default_nettype none

module jump_unit (
  input  wire                          clk,
  input  wire                          rst,

  input  wire                          i_fetched,
  input  wire  [fetch_pkg::ADDR_W-1:0] i_pc,
  input  wire  [fetch_pkg::INST_W-1:0] i_inst,

  output logic                         o_dec_valid,
  output logic [fetch_pkg::ADDR_W-1:0] o_pc,
  output logic [fetch_pkg::INST_W-1:0] o_inst,
  output logic                         o_jmp,
  output logic [fetch_pkg::ADDR_W-1:0] o_jmp_addr
);

  logic [20:0]                  imm_j;      // 21 bit, lsb always zero
  logic [fetch_pkg::ADDR_W-1:0] imm_j_sx;

  ////////////////////////////////////////
  // decode register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      o_dec_valid <= 1'b0;
    end else begin
      o_dec_valid <= i_fetched;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched) begin
      o_pc   <= i_pc;
      o_inst <= i_inst;
    end
  end

  ////////////////////////////////////////
  // jal target
  ////////////////////////////////////////

  // imm[20|10:1|11|19:12] sits in inst[31:12]
  assign imm_j = {
    o_inst[31],     // imm[20]
    o_inst[19:12],  // imm[19:12]
    o_inst[20],     // imm[11]
    o_inst[30:21],  // imm[10:1]
    1'b0
  };

  assign imm_j_sx = {{(fetch_pkg::ADDR_W - 21){imm_j[20]}}, imm_j};

  assign o_jmp_addr = o_pc + imm_j_sx;

  // only valid words can redirect
  assign o_jmp = o_dec_valid & (o_inst[6:0] == fetch_pkg::OPC_JAL);

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
// fetch unit
// holds the pc, drives the instruction bus and refetches once after a jump
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter logic [fetch_pkg::ADDR_W-1:0] PC_START = fetch_pkg::PC_START_DEF
) (
  input  wire                          clk,
  input  wire                          rst,

  ////////////////////////////////////////
  // instruction bus
  input  wire                          i_bus_ack,
  input  wire  [fetch_pkg::INST_W-1:0] i_bus_rdata,
  output logic                         o_bus_req,
  output logic [fetch_pkg::ADDR_W-1:0] o_bus_addr,

  ////////////////////////////////////////
  // pipeline side
  input  wire                          i_writebacked_req,  // start next fetch
  input  wire                          i_pc_jmp,
  input  wire  [fetch_pkg::ADDR_W-1:0] i_pc_jmpaddr,
  output logic [fetch_pkg::ADDR_W-1:0] o_pc,
  output logic [fetch_pkg::INST_W-1:0] o_inst,
  output logic                         o_fetched            // one cycle pulse
);

  logic                         handshake;
  logic                         redirect;
  logic                         fetch_again;    // next word is a wasted one
  logic [fetch_pkg::ADDR_W-1:0] pc_pred;        // pc after the last fetched word
  logic [fetch_pkg::ADDR_W-1:0] saved_jmpaddr;  // target held until refetch

  assign handshake = o_bus_req & i_bus_ack;

  // a jump only matters when it leaves the sequential path,
  // so an offset of 4 falls through with no refetch
  assign redirect = i_pc_jmp & (i_pc_jmpaddr != pc_pred);

  ////////////////////////////////////////
  // bus request
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_req <= 1'b1;  // first fetch starts right out of reset
    end else if (handshake) begin
      if (!fetch_again) begin
        o_bus_req <= 1'b0;
      end                 // refetch keeps req high for the target
    end else if (i_writebacked_req) begin
      o_bus_req <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // address, prediction and refetch flag
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_addr  <= PC_START;
      pc_pred     <= PC_START;
      fetch_again <= 1'b0;
      o_fetched   <= 1'b0;
    end else begin
      o_fetched <= 1'b0;
      if (handshake) begin
        if (fetch_again) begin
          // drop the sequential word, go to the target
          fetch_again <= 1'b0;
          o_bus_addr  <= saved_jmpaddr;
          pc_pred     <= saved_jmpaddr;
        end else begin
          o_bus_addr <= o_bus_addr + 64'd4;
          pc_pred    <= o_bus_addr + 64'd4;
          o_fetched  <= 1'b1;
        end
      end
      // jump is decoded while the bus is idle, never in a handshake cycle
      if (redirect) begin
        fetch_again <= 1'b1;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (redirect) begin
      saved_jmpaddr <= i_pc_jmpaddr;
    end
    if (handshake && !fetch_again) begin
      o_pc   <= o_bus_addr;
      o_inst <= i_bus_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
// fetch package
// widths and fixed encodings shared by the fetch subsystem
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  parameter int ADDR_W = 64;  // pc and bus address
  parameter int INST_W = 32;  // one instruction word

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // major opcode of jal, bits [6:0] of the word
  parameter logic [6:0] OPC_JAL = 7'b1101111;

  // ebreak is a complete fixed word, no fields to decode
  parameter logic [INST_W-1:0] INST_EBREAK = 32'h0010_0073;

  ////////////////////////////////////////
  // reset pc
  ////////////////////////////////////////

  // default boot address, the top level can override it
  parameter logic [ADDR_W-1:0] PC_START_DEF = 64'h0000_0000_8000_0000;

endpackage

`default_nettype wire
